// File: branchPred_defines.svh
/*
  Sizing macros for the tournament branch predictor.
  Include this header in any file that needs the index or PC width.
*/

`ifndef BRANCH_PRED_DEFINES_SVH
`define BRANCH_PRED_DEFINES_SVH

// width of every table index and of the global history
// 64 entries per table, PC bits [7:2] feed each index
`define BP_INDEX_BITS 6

// program counter width
`define BP_PC_BITS 32

`endif

// File: bpPkg.sv
/*
  Shared types for the tournament predictor.
  Holds the 2-bit counter encoding, the per-cycle table operation
  and the saturating counter step used by all three tables.
*/
`default_nettype none

package bpPkg;

  // upper bit is the predicted direction (or "use gshare" in the chooser)
  typedef enum logic [1:0] {
    strongNotTaken = 2'b00,
    weakNotTaken   = 2'b01,
    weakTaken      = 2'b10,
    strongTaken    = 2'b11
  } counterState;

  // operation broadcast by the control to every table each cycle
  typedef enum logic [1:0] {
    opIdle     = 2'b00,
    opPredict  = 2'b01,
    opUpdRead  = 2'b10,
    opUpdWrite = 2'b11
  } tableOp;

  // saturating step, up when taken, down when not
  function automatic counterState satUpdate(counterState cur, logic taken);
    counterState nxt;
    nxt = cur;
    if (taken && cur != strongTaken) nxt = counterState'(cur + 2'd1);
    else if (!taken && cur != strongNotTaken) nxt = counterState'(cur - 2'd1);
    return nxt;
  endfunction

endpackage

`default_nettype wire

// File: phtRam.sv
/*
  Pattern history array of 2-bit counters.
  One combinational read port and one clocked write port. A read of the
  entry being written returns the new value in the same cycle.
*/
`include "branchPred_defines.svh"
`default_nettype none

module phtRam (
  input  logic                       clk,
  input  logic                       arstN,
  input  logic [`BP_INDEX_BITS-1:0]  readIndex,
  input  logic                       writeEnable,
  input  logic [`BP_INDEX_BITS-1:0]  writeIndex,
  input  bpPkg::counterState         writeData,
  output bpPkg::counterState         readData
);

  localparam int Entries = 1 << `BP_INDEX_BITS;

  bpPkg::counterState mem [Entries];

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  // every counter starts weakly not taken
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < Entries; i++) begin
        mem[i] <= bpPkg::weakNotTaken;
      end
    end else if (writeEnable) begin
      mem[writeIndex] <= writeData;
    end
  end

  // read-during-write bypass so the new counter is seen at once
  assign readData = (writeEnable && writeIndex == readIndex) ? writeData : mem[readIndex];

  // the write side must always carry a real counter value
  writeDataKnown: assert property (@(posedge clk) disable iff (!arstN)
    writeEnable |-> !$isunknown(writeData));

endmodule

`default_nettype wire

// File: gshareTable.sv
/*
  Gshare component: counters indexed by PC xor global history.
  Owns the speculative GHR, shifting on accepted predictions and
  restoring from the core's snapshot on a mispredicted update.
*/
`include "branchPred_defines.svh"
`default_nettype none

module gshareTable (
  input  logic                       clk,
  input  logic                       arstN,
  input  bpPkg::tableOp              op,
  input  logic [`BP_PC_BITS-1:0]     lookupPc,
  input  logic [`BP_PC_BITS-1:0]     updPc,
  input  logic                       updTaken,
  input  logic                       updMispredict,
  input  logic [`BP_INDEX_BITS-1:0]  updGhr,
  input  logic                       predAccept,
  input  logic                       finalTaken,
  output logic [`BP_INDEX_BITS-1:0]  ghr,
  output logic                       predTaken,
  output logic                       updPredTaken
);

  logic [`BP_INDEX_BITS-1:0] histSel;
  logic [`BP_INDEX_BITS-1:0] readIndex;
  logic [`BP_INDEX_BITS-1:0] updIndex;
  logic [`BP_INDEX_BITS-1:0] indexQ;
  bpPkg::counterState        readData;
  bpPkg::counterState        counterQ;
  logic                      takenQ;

  ////////////////////////////////////////////////////////////
  // indexing
  ////////////////////////////////////////////////////////////

  // an update re-reads with the history the branch was predicted under
  assign histSel   = (op == bpPkg::opUpdRead) ? updGhr : ghr;
  assign readIndex = histSel ^ lookupPc[`BP_INDEX_BITS+1:2];
  assign updIndex  = updGhr ^ updPc[`BP_INDEX_BITS+1:2];

  phtRam pht (
    .clk(clk), .arstN(arstN), .readIndex(readIndex),
    .writeEnable(op == bpPkg::opUpdWrite), .writeIndex(indexQ),
    .writeData(bpPkg::satUpdate(counterQ, takenQ)), .readData(readData)
  );

  assign predTaken    = readData[1];
  // direction this table would have given, for chooser training
  assign updPredTaken = counterQ[1];

  // hold the counter, index and outcome for the write cycle
  always_ff @(posedge clk) begin
    if (op == bpPkg::opUpdRead) begin
      counterQ <= readData;
      indexQ   <= updIndex;
      takenQ   <= updTaken;
    end
  end

  ////////////////////////////////////////////////////////////
  // speculative history
  ////////////////////////////////////////////////////////////

  // newest outcome enters at bit 0, oldest falls off the top
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ghr <= '0;
    end else if (op == bpPkg::opUpdRead && updMispredict) begin
      ghr <= {updGhr[`BP_INDEX_BITS-2:0], updTaken};
    end else if (predAccept) begin
      ghr <= {ghr[`BP_INDEX_BITS-2:0], finalTaken};
    end
  end

  // control must never accept a prediction alongside an update read
  noPredDuringUpd: assert property (@(posedge clk) disable iff (!arstN)
    !(predAccept && op == bpPkg::opUpdRead));

endmodule

`default_nettype wire

// File: bimodalTable.sv
/*
  Bimodal component: counters indexed by PC bits alone.
  Reads combinationally for predictions, trains over the two-cycle
  update sequence driven by the control.
*/
`include "branchPred_defines.svh"
`default_nettype none

module bimodalTable (
  input  logic                    clk,
  input  logic                    arstN,
  input  bpPkg::tableOp           op,
  input  logic [`BP_PC_BITS-1:0]  lookupPc,
  input  logic [`BP_PC_BITS-1:0]  updPc,
  input  logic                    updTaken,
  output logic                    predTaken,
  output logic                    updPredTaken
);

  logic [`BP_INDEX_BITS-1:0] indexQ;
  bpPkg::counterState        readData;
  bpPkg::counterState        counterQ;
  logic                      takenQ;

  // lookupPc already carries updPc during an update read
  phtRam pht (
    .clk(clk), .arstN(arstN), .readIndex(lookupPc[`BP_INDEX_BITS+1:2]),
    .writeEnable(op == bpPkg::opUpdWrite), .writeIndex(indexQ),
    .writeData(bpPkg::satUpdate(counterQ, takenQ)), .readData(readData)
  );

  assign predTaken    = readData[1];
  assign updPredTaken = counterQ[1];

  // capture for the write cycle
  always_ff @(posedge clk) begin
    if (op == bpPkg::opUpdRead) begin
      counterQ <= readData;
      indexQ   <= updPc[`BP_INDEX_BITS+1:2];
      takenQ   <= updTaken;
    end
  end

endmodule

`default_nettype wire

// File: choiceTable.sv
/*
  Chooser for the tournament predictor.
  A PC-indexed counter picks gshare (upper bit set) or bimodal per branch.
  Trains only when the two components disagreed on the resolved branch.
*/
`include "branchPred_defines.svh"
`default_nettype none

module choiceTable (
  input  logic                    clk,
  input  logic                    arstN,
  input  bpPkg::tableOp           op,
  input  logic [`BP_PC_BITS-1:0]  lookupPc,
  input  logic [`BP_PC_BITS-1:0]  updPc,
  input  logic                    updTaken,
  input  logic                    gsharePredTaken,
  input  logic                    bimodalPredTaken,
  input  logic                    gshareUpdTaken,
  input  logic                    bimodalUpdTaken,
  output logic                    finalTaken
);

  logic [`BP_INDEX_BITS-1:0] indexQ;
  bpPkg::counterState        readData;
  bpPkg::counterState        counterQ;
  logic                      takenQ;
  logic                      disagree;
  logic                      gshareRight;

  ////////////////////////////////////////////////////////////
  // selection
  ////////////////////////////////////////////////////////////

  phtRam pht (
    .clk(clk), .arstN(arstN), .readIndex(lookupPc[`BP_INDEX_BITS+1:2]),
    .writeEnable(op == bpPkg::opUpdWrite && disagree), .writeIndex(indexQ),
    .writeData(bpPkg::satUpdate(counterQ, gshareRight)), .readData(readData)
  );

  assign finalTaken = readData[1] ? gsharePredTaken : bimodalPredTaken;

  ////////////////////////////////////////////////////////////
  // training
  ////////////////////////////////////////////////////////////

  // component bits arrive registered from the update read
  assign disagree    = gshareUpdTaken != bimodalUpdTaken;
  // step toward gshare when it got it right, else toward bimodal
  assign gshareRight = gshareUpdTaken == takenQ;

  always_ff @(posedge clk) begin
    if (op == bpPkg::opUpdRead) begin
      counterQ <= readData;
      indexQ   <= updPc[`BP_INDEX_BITS+1:2];
      takenQ   <= updTaken;
    end
  end

endmodule

`default_nettype wire

// File: predictorControl.sv
/*
  Sequencing and handshakes for the predictor.
  Arbitrates predictions against updates (updates win), runs the
  two-cycle update, and holds the registered prediction response.
*/
`include "branchPred_defines.svh"
`default_nettype none

module predictorControl (
  input  logic                       clk,
  input  logic                       arstN,
  input  logic                       predValid,
  input  logic [`BP_PC_BITS-1:0]     predPc,
  input  logic                       respReady,
  input  logic                       updValid,
  input  logic [`BP_PC_BITS-1:0]     updPc,
  input  logic                       finalTaken,
  input  logic [`BP_INDEX_BITS-1:0]  ghr,
  output logic                       predReady,
  output logic                       respValid,
  output logic                       respTaken,
  output logic [`BP_INDEX_BITS-1:0]  respGhr,
  output logic                       updReady,
  output bpPkg::tableOp              op,
  output logic [`BP_PC_BITS-1:0]     lookupPc,
  output logic                       predAccept,
  output logic                       updAccept
);

  bpPkg::tableOp stateQ;
  logic          inWrite;
  logic          respHeld;

  ////////////////////////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////////////////////////

  assign inWrite  = stateQ == bpPkg::opUpdWrite;
  assign respHeld = respValid && !respReady;

  assign updReady   = !inWrite;
  assign updAccept  = updValid && updReady;
  // a pending update always blocks the prediction side
  assign predReady  = !updValid && !inWrite && !respHeld;
  assign predAccept = predValid && predReady;

  always_comb begin
    if (inWrite) op = bpPkg::opUpdWrite;
    else if (updAccept) op = bpPkg::opUpdRead;
    else if (predAccept) op = bpPkg::opPredict;
    else op = bpPkg::opIdle;
  end

  assign lookupPc = updValid ? updPc : predPc;

  // one write cycle follows every accepted update
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) stateQ <= bpPkg::opIdle;
    else stateQ <= updAccept ? bpPkg::opUpdWrite : bpPkg::opIdle;
  end

  ////////////////////////////////////////////////////////////
  // response register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      respValid <= 1'b0;
    end else if (predAccept) begin
      respValid <= 1'b1;
    end else if (respReady) begin
      respValid <= 1'b0;
    end
  end

  // snapshot is the history before this prediction's shift
  always_ff @(posedge clk) begin
    if (predAccept) begin
      respTaken <= finalTaken;
      respGhr   <= ghr;
    end
  end

  respStable: assert property (@(posedge clk) disable iff (!arstN)
    respHeld |=> $stable(respTaken) && $stable(respGhr));

  writeBlocksUpd: assert property (@(posedge clk) disable iff (!arstN)
    updAccept |=> !updReady);

endmodule

`default_nettype wire

// File: tournamentPredictor.sv
/*
  Top level of the tournament direction predictor.
  Ties the control to the gshare, bimodal and chooser tables.
  Drive predPc with predValid, collect respTaken/respGhr, send resolved
  branches back on the upd* port with the returned history snapshot.
*/
`include "branchPred_defines.svh"
`default_nettype none

module tournamentPredictor (
  input  logic                       clk,
  input  logic                       arstN,
  input  logic                       predValid,
  output logic                       predReady,
  input  logic [`BP_PC_BITS-1:0]     predPc,
  output logic                       respValid,
  input  logic                       respReady,
  output logic                       respTaken,
  output logic [`BP_INDEX_BITS-1:0]  respGhr,
  input  logic                       updValid,
  output logic                       updReady,
  input  logic [`BP_PC_BITS-1:0]     updPc,
  input  logic                       updTaken,
  input  logic                       updMispredict,
  input  logic [`BP_INDEX_BITS-1:0]  updGhr
);

  bpPkg::tableOp             op;
  logic [`BP_PC_BITS-1:0]    lookupPc;
  logic [`BP_INDEX_BITS-1:0] ghr;
  logic                      predAccept;
  logic                      gsharePredTaken, bimodalPredTaken;
  logic                      gshareUpdTaken, bimodalUpdTaken;
  logic                      finalTaken;

  ////////////////////////////////////////////////////////////
  // control and components
  ////////////////////////////////////////////////////////////

  predictorControl ctrl (
    .clk(clk), .arstN(arstN), .predValid(predValid), .predPc(predPc),
    .respReady(respReady), .updValid(updValid), .updPc(updPc),
    .finalTaken(finalTaken), .ghr(ghr), .predReady(predReady),
    .respValid(respValid), .respTaken(respTaken), .respGhr(respGhr),
    .updReady(updReady), .op(op), .lookupPc(lookupPc),
    .predAccept(predAccept), .updAccept()
  );

  gshareTable gshare (
    .clk(clk), .arstN(arstN), .op(op), .lookupPc(lookupPc), .updPc(updPc),
    .updTaken(updTaken), .updMispredict(updMispredict), .updGhr(updGhr),
    .predAccept(predAccept), .finalTaken(finalTaken), .ghr(ghr),
    .predTaken(gsharePredTaken), .updPredTaken(gshareUpdTaken)
  );

  bimodalTable bimodal (
    .clk(clk), .arstN(arstN), .op(op), .lookupPc(lookupPc), .updPc(updPc),
    .updTaken(updTaken), .predTaken(bimodalPredTaken),
    .updPredTaken(bimodalUpdTaken)
  );

  // chooser picks the final direction, which also feeds the GHR shift
  choiceTable chooser (
    .clk(clk), .arstN(arstN), .op(op), .lookupPc(lookupPc), .updPc(updPc),
    .updTaken(updTaken), .gsharePredTaken(gsharePredTaken),
    .bimodalPredTaken(bimodalPredTaken), .gshareUpdTaken(gshareUpdTaken),
    .bimodalUpdTaken(bimodalUpdTaken), .finalTaken(finalTaken)
  );

endmodule

`default_nettype wire

// File: tbTournament.sv
/*
  Testbench for the tournament predictor.
  Reads predictorTests.txt from the project root. P lines predict and check
  the response, U lines resolve the oldest outstanding response.
*/
`include "branchPred_defines.svh"
`default_nettype none

module tbTournament;

  localparam int Timeout = 50;

  logic                      clk;
  logic                      arstN;
  logic                      predValid;
  logic                      predReady;
  logic [`BP_PC_BITS-1:0]    predPc;
  logic                      respValid;
  logic                      respReady;
  logic                      respTaken;
  logic [`BP_INDEX_BITS-1:0] respGhr;
  logic                      updValid;
  logic                      updReady;
  logic [`BP_PC_BITS-1:0]    updPc;
  logic                      updTaken;
  logic                      updMispredict;
  logic [`BP_INDEX_BITS-1:0] updGhr;

  // one entry per record of the test file
  logic [7:0]                kinds [$];
  logic [31:0]               pcs [$];
  logic [31:0]               fieldA [$];
  logic [31:0]               fieldB [$];
  // snapshots of unresolved responses in arrival order
  logic [`BP_INDEX_BITS-1:0] snapshots [$];

  int mismatches;
  int failures;

  tournamentPredictor uut (
    .clk(clk), .arstN(arstN), .predValid(predValid), .predReady(predReady),
    .predPc(predPc), .respValid(respValid), .respReady(respReady),
    .respTaken(respTaken), .respGhr(respGhr), .updValid(updValid),
    .updReady(updReady), .updPc(updPc), .updTaken(updTaken),
    .updMispredict(updMispredict), .updGhr(updGhr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////

  task automatic endRun();
    $display("mismatches: %0d, other failures: %0d", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
    mismatches++;
  endtask

  task automatic reportFailure(input string what);
    $display("error at %0t: %s", $time, what);
    failures++;
  endtask

  // a handshake that never arrives ends the run
  task automatic timeoutAbort(input string what);
    $display("timeout waiting for %s at %0t", what, $time);
    failures++;
    endRun();
  endtask

  ////////////////////////////////////////////////////////////
  // port drivers
  ////////////////////////////////////////////////////////////

  // drive point sits just after the rising edge
  task automatic nextCycle();
    @(posedge clk);
    #2;
  endtask

  task automatic acceptPrediction(input logic [31:0] pc);
    int count;
    count = 0;
    predValid = 1'b1;
    predPc    = pc;
    @(negedge clk);
    while (!predReady && count < Timeout) begin
      @(negedge clk);
      count++;
    end
    if (!predReady) timeoutAbort("predReady");
    // transfer happens on this edge
    nextCycle();
    predValid = 1'b0;
  endtask

  task automatic collectResponse(input logic expTaken, input logic [`BP_INDEX_BITS-1:0] expGhr);
    int                        count;
    int                        holdCycles;
    logic                      heldTaken;
    logic [`BP_INDEX_BITS-1:0] heldGhr;
    count = 0;
    @(negedge clk);
    while (!respValid && count < Timeout) begin
      @(negedge clk);
      count++;
    end
    if (!respValid) timeoutAbort("respValid");
    heldTaken  = respTaken;
    heldGhr    = respGhr;
    holdCycles = $urandom % 3;
    // back-pressure freezes the response and blocks new predictions
    repeat (holdCycles) begin
      @(negedge clk);
      if (predReady !== 1'b0) reportMismatch("predReady", 32'(1'b0), 32'(predReady));
      if (respTaken !== heldTaken) reportMismatch("respTaken", 32'(heldTaken), 32'(respTaken));
      if (respGhr !== heldGhr) reportMismatch("respGhr", 32'(heldGhr), 32'(respGhr));
    end
    nextCycle();
    respReady = 1'b1;
    @(negedge clk);
    if (respValid !== 1'b1) reportMismatch("respValid", 32'(1'b1), 32'(respValid));
    if (respTaken !== expTaken) reportMismatch("respTaken", 32'(expTaken), 32'(respTaken));
    if (respGhr !== expGhr) reportMismatch("respGhr", 32'(expGhr), 32'(respGhr));
    nextCycle();
    respReady = 1'b0;
    snapshots.push_back(expGhr);
  endtask

  // withPred raises the next prediction together with the update
  task automatic sendUpdate(input logic [31:0] pc, input logic taken, input logic mispredict,
                            input logic withPred, input logic [31:0] nextPc);
    int count;
    count = 0;
    if (snapshots.size() == 0) begin
      reportFailure("update record without an outstanding response");
    end else begin
      updGhr = snapshots.pop_front();
    end
    updValid      = 1'b1;
    updPc         = pc;
    updTaken      = taken;
    updMispredict = mispredict;
    if (withPred) begin
      predValid = 1'b1;
      predPc    = nextPc;
    end
    do begin
      @(negedge clk);
      if (withPred && predReady !== 1'b0) begin
        reportMismatch("predReady", 32'(1'b0), 32'(predReady));
      end
      count++;
    end while (!updReady && count < Timeout);
    if (!updReady) timeoutAbort("updReady");
    nextCycle();
    updValid = 1'b0;
    // write cycle blocks both ports
    @(negedge clk);
    if (updReady !== 1'b0) reportMismatch("updReady", 32'(1'b0), 32'(updReady));
    if (withPred && predReady !== 1'b0) reportMismatch("predReady", 32'(1'b0), 32'(predReady));
    nextCycle();
    if (updReady !== 1'b1) reportMismatch("updReady", 32'(1'b1), 32'(updReady));
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          fd;
    int          fields;
    int          idleCycles;
    int unsigned seedInit;
    string       line;
    logic [7:0]  kind;
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
    logic        nextIsPred;
    logic [31:0] nextPc;
    mismatches    = 0;
    failures      = 0;
    seedInit      = $urandom(32'h0023_adf7);
    arstN         = 1'b0;
    predValid     = 1'b0;
    predPc        = '0;
    respReady     = 1'b0;
    updValid      = 1'b0;
    updPc         = '0;
    updTaken      = 1'b0;
    updMispredict = 1'b0;
    updGhr        = '0;

    fd = $fopen("predictorTests.txt", "r");
    if (fd == 0) begin
      reportFailure("cannot open predictorTests.txt");
      endRun();
    end
    while ($fgets(line, fd) != 0) begin
      // skip blank lines and the column notes
      if (line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%c %h %h %h", kind, pc, a, b);
        if (fields == 4) begin
          kinds.push_back(kind);
          pcs.push_back(pc);
          fieldA.push_back(a);
          fieldB.push_back(b);
        end else begin
          reportFailure("malformed record in predictorTests.txt");
        end
      end
    end
    $fclose(fd);

    repeat (2) @(posedge clk);
    #2;
    arstN = 1'b1;
    @(negedge clk);
    if (respValid !== 1'b0) reportMismatch("respValid", 32'(1'b0), 32'(respValid));
    if (predReady !== 1'b1) reportMismatch("predReady", 32'(1'b1), 32'(predReady));
    if (updReady !== 1'b1) reportMismatch("updReady", 32'(1'b1), 32'(updReady));
    nextCycle();

    for (int k = 0; k < kinds.size(); k++) begin
      a = fieldA[k];
      b = fieldB[k];
      // no idle gap while a prediction is already being offered
      if (!predValid) begin
        idleCycles = $urandom % 3;
        repeat (idleCycles) nextCycle();
      end
      if (kinds[k] == "P") begin
        acceptPrediction(pcs[k]);
        collectResponse(a[0], b[`BP_INDEX_BITS-1:0]);
      end else if (kinds[k] == "U") begin
        nextIsPred = (k + 1 < kinds.size()) && (kinds[k + 1] == "P");
        nextPc     = nextIsPred ? pcs[k + 1] : '0;
        sendUpdate(pcs[k], a[0], b[0], nextIsPred, nextPc);
      end else begin
        reportFailure("unknown record kind in predictorTests.txt");
      end
    end

    nextCycle();
    endRun();
  end

endmodule

`default_nettype wire

// File: predictorTests.txt
# P pc expectedTaken expectedGhr   (prediction, hex)
# U pc actualTaken mispredict      (update, uses the oldest response's GHR)
P 00000040 0 00
U 00000040 1 1
P 00000040 1 01
U 00000040 1 0
P 00000084 0 03
U 00000084 0 0
P 000000c8 0 06
U 000000c8 1 1
P 000000c8 1 0d
U 000000c8 0 1
P 000000c8 0 1a
U 000000c8 1 1
P 000000c8 0 35
U 000000c8 0 0
P 000000c8 0 2a
U 000000c8 1 1
P 000000c8 0 15
U 000000c8 0 0
P 000000c8 1 2a
U 000000c8 1 0
P 000000c8 0 15
U 000000c8 0 0
P 000000c8 1 2a

// File: compile.f
+incdir+.
bpPkg.sv
phtRam.sv
gshareTable.sv
bimodalTable.sv
choiceTable.sv
predictorControl.sv
tournamentPredictor.sv
tbTournament.sv

// File: runSim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and judge the result from its output
verilator --binary --timing --assert -f compile.f --top-module tbTournament \
  -o simTournament || { echo "build failed"; exit 1; }
out="$(./obj_dir/simTournament)"
echo "$out"
echo "$out" | grep -q "Simulation finished: PASS" && echo "run passed" ||
  { echo "run failed"; exit 1; }
